/* logic/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// datapath widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_REG_IDX_W       6
`define CSR_CYCLE_W         64

// ====================
// csr addresses
// ====================
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
// custom machine read/write range
`define CSR_ADDR_MTIMECMP   12'h7c0
`define CSR_ADDR_MTIMECMPH  12'h7c1
`define CSR_ADDR_MCYCLE     12'hb00
`define CSR_ADDR_MCYCLEH    12'hb80
`define CSR_ADDR_CYCLE      12'hc00
`define CSR_ADDR_CYCLEH     12'hc80
`define CSR_ADDR_MVENDORID  12'hf11
`define CSR_ADDR_MARCHID    12'hf12
`define CSR_ADDR_MIMPID     12'hf13
`define CSR_ADDR_MHARTID    12'hf14

// ====================
// funct codes
// ====================
`define CSR_F3_PRIV         3'b000
`define CSR_F3_CSRRW        3'b001
`define CSR_F3_CSRRS        3'b010
`define CSR_F3_CSRRC        3'b011
`define CSR_F3_CSRRWI       3'b101
`define CSR_F3_CSRRSI       3'b110
`define CSR_F3_CSRRCI       3'b111

`define CSR_F12_ECALL       12'h000
`define CSR_F12_EBREAK      12'h001
`define CSR_F12_MRET        12'h302

// trap causes
`define CSR_CAUSE_ECALL_M   11
`define CSR_CAUSE_BREAK     3

// rv32i, mxl = 1
`define CSR_MISA_VALUE      32'h4000_0100

// bit positions inside mstatus, mie and mip
`define CSR_MSTATUS_MIE     3
`define CSR_MSTATUS_MPIE    7
`define CSR_BIT_MSI         3
`define CSR_BIT_MTI         7
`define CSR_BIT_MEI         11

`endif

/* logic/csr_pkg.sv */
`include "csr_params.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]      xlen_t;
    typedef logic [`CSR_ADDR_W-1:0]    csr_addr_t;
    typedef logic [`CSR_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`CSR_CYCLE_W-1:0]   cycle_t;

    // instruction handed over by issue
    typedef struct packed {
        xlen_t    instr;
        xlen_t    rs1_val;
        xlen_t    pc;
        logic     rd_en;
        reg_idx_t rd_idx;
    } instr_pld_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    // one-cycle trap event, exc and mret are exclusive
    typedef struct packed {
        logic  exc;
        logic  mret;
        xlen_t cause;
        xlen_t pc;
        xlen_t instr;
    } trap_evt_t;

    typedef struct packed {
        logic mie;
        logic meie;
        logic mtie;
        logic msie;
    } irq_ctl_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        xlen_t    val;
    } rd_wr_t;

    typedef struct packed {
        logic  en;
        xlen_t target;
    } redirect_t;

endpackage

/* logic/csr_exec.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_exec (
    input  logic               instr_vld,
    input  csr_pkg::instr_pld_t instr,
    input  csr_pkg::xlen_t     trap_rdata,
    input  csr_pkg::xlen_t     timer_rdata,
    input  csr_pkg::xlen_t     mtvec,
    input  csr_pkg::xlen_t     mepc,
    output csr_pkg::csr_addr_t csr_addr,
    output csr_pkg::csr_wr_t   csr_wr,
    output csr_pkg::trap_evt_t trap_evt,
    output csr_pkg::rd_wr_t    rd_wr,
    output csr_pkg::redirect_t redirect
);

    logic [2:0]         funct3;
    logic [11:0]        funct12;
    csr_pkg::xlen_t     imm;
    csr_pkg::xlen_t     local_rdata;
    csr_pkg::xlen_t     old_val;
    csr_pkg::xlen_t     wdata;
    logic               wr_en;
    logic               is_priv;
    logic               exc_en;
    logic               mret_en;

    // ====================
    // decode
    // ====================
    assign funct3   = instr.instr[14:12];
    assign funct12  = instr.instr[31:20];
    assign csr_addr = instr.instr[31:20];
    // zimm sits in the rs1 field
    assign imm      = {{(`CSR_XLEN-5){1'b0}}, instr.instr[19:15]};
    assign is_priv  = (funct3 == `CSR_F3_PRIV);
    assign wr_en    = instr_vld & instr.rd_en;

    // identity, delegation and misa are constants
    always_comb begin
        case (csr_addr)
            `CSR_ADDR_MISA: local_rdata = `CSR_MISA_VALUE;
            `CSR_ADDR_MVENDORID,
            `CSR_ADDR_MARCHID,
            `CSR_ADDR_MIMPID,
            `CSR_ADDR_MHARTID,
            `CSR_ADDR_MEDELEG,
            `CSR_ADDR_MIDELEG: local_rdata = '0;
            default: local_rdata = '0;
        endcase
    end

    // each block returns zero for addresses it does not own
    assign old_val = trap_rdata | timer_rdata | local_rdata;

    always_comb begin
        case (funct3)
            `CSR_F3_CSRRW:  wdata = instr.rs1_val;
            `CSR_F3_CSRRS:  wdata = old_val | instr.rs1_val;
            `CSR_F3_CSRRC:  wdata = old_val & ~instr.rs1_val;
            `CSR_F3_CSRRWI: wdata = imm;
            `CSR_F3_CSRRSI: wdata = old_val | imm;
            `CSR_F3_CSRRCI: wdata = old_val & ~imm;
            default:        wdata = '0;
        endcase
    end

    assign csr_wr.en   = wr_en;
    assign csr_wr.addr = csr_addr;
    assign csr_wr.data = wdata;

    assign rd_wr.en  = wr_en;
    assign rd_wr.idx = instr.rd_idx;
    assign rd_wr.val = old_val;

    // ====================
    // traps
    // ====================
    assign exc_en  = instr_vld & is_priv &
                     ((funct12 == `CSR_F12_ECALL) | (funct12 == `CSR_F12_EBREAK));
    assign mret_en = instr_vld & is_priv & (funct12 == `CSR_F12_MRET);

    assign trap_evt.exc   = exc_en;
    assign trap_evt.mret  = mret_en;
    assign trap_evt.cause = (funct12 == `CSR_F12_ECALL) ? `CSR_CAUSE_ECALL_M : `CSR_CAUSE_BREAK;
    assign trap_evt.pc    = instr.pc;
    assign trap_evt.instr = instr.instr;

    assign redirect.en     = exc_en | mret_en;
    assign redirect.target = exc_en ? mtvec : mepc;

endmodule

/* logic/csr_trap_regs.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_trap_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_wr_t   csr_wr,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::trap_evt_t trap_evt,
    output csr_pkg::xlen_t     rdata,
    output csr_pkg::xlen_t     mtvec,
    output csr_pkg::xlen_t     mepc,
    output csr_pkg::irq_ctl_t  irq_ctl
);

    logic           mst_mie;
    logic           mst_mpie;
    logic           mie_msie;
    logic           mie_mtie;
    logic           mie_meie;
    csr_pkg::xlen_t mtvec_q;
    csr_pkg::xlen_t mepc_q;
    csr_pkg::xlen_t mcause_q;
    csr_pkg::xlen_t mtval_q;
    csr_pkg::xlen_t mscratch_q;
    csr_pkg::xlen_t mstatus_rd;
    csr_pkg::xlen_t mie_rd;

    // ====================
    // mstatus
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mst_mie  <= 1'b0;
            mst_mpie <= 1'b0;
        end else if (trap_evt.exc) begin
            mst_mie  <= 1'b0;
            mst_mpie <= mst_mie;
        end else if (trap_evt.mret) begin
            mst_mie  <= mst_mpie;
            mst_mpie <= 1'b1;
        end else if (csr_wr.en && csr_wr.addr == `CSR_ADDR_MSTATUS) begin
            mst_mie  <= csr_wr.data[`CSR_MSTATUS_MIE];
            mst_mpie <= csr_wr.data[`CSR_MSTATUS_MPIE];
        end
    end

    // only the machine enables exist
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_msie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_meie <= 1'b0;
        end else if (csr_wr.en && csr_wr.addr == `CSR_ADDR_MIE) begin
            mie_msie <= csr_wr.data[`CSR_BIT_MSI];
            mie_mtie <= csr_wr.data[`CSR_BIT_MTI];
            mie_meie <= csr_wr.data[`CSR_BIT_MEI];
        end
    end

    // mode 2 and 3 are reserved, so the mode field holds its value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (csr_wr.en && csr_wr.addr == `CSR_ADDR_MTVEC) begin
            mtvec_q[`CSR_XLEN-1:2] <= csr_wr.data[`CSR_XLEN-1:2];
            if (!csr_wr.data[1]) begin
                mtvec_q[1:0] <= csr_wr.data[1:0];
            end
        end
    end

    // ====================
    // trap handling
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else if (trap_evt.exc) begin
            mepc_q   <= trap_evt.pc;
            mcause_q <= trap_evt.cause;
            mtval_q  <= trap_evt.instr;
        end else if (csr_wr.en) begin
            case (csr_wr.addr)
                `CSR_ADDR_MEPC:   mepc_q   <= csr_wr.data;
                `CSR_ADDR_MCAUSE: mcause_q <= csr_wr.data;
                `CSR_ADDR_MTVAL:  mtval_q  <= csr_wr.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch_q <= '0;
        end else if (csr_wr.en && csr_wr.addr == `CSR_ADDR_MSCRATCH) begin
            mscratch_q <= csr_wr.data;
        end
    end

    // read port
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[`CSR_MSTATUS_MIE]  = mst_mie;
        mstatus_rd[`CSR_MSTATUS_MPIE] = mst_mpie;
        mie_rd = '0;
        mie_rd[`CSR_BIT_MSI] = mie_msie;
        mie_rd[`CSR_BIT_MTI] = mie_mtie;
        mie_rd[`CSR_BIT_MEI] = mie_meie;
        case (csr_addr)
            `CSR_ADDR_MSTATUS:  rdata = mstatus_rd;
            `CSR_ADDR_MIE:      rdata = mie_rd;
            `CSR_ADDR_MTVEC:    rdata = mtvec_q;
            `CSR_ADDR_MEPC:     rdata = mepc_q;
            `CSR_ADDR_MCAUSE:   rdata = mcause_q;
            `CSR_ADDR_MTVAL:    rdata = mtval_q;
            `CSR_ADDR_MSCRATCH: rdata = mscratch_q;
            default:            rdata = '0;
        endcase
    end

    assign mtvec        = mtvec_q;
    assign mepc         = mepc_q;
    assign irq_ctl.mie  = mst_mie;
    assign irq_ctl.meie = mie_meie;
    assign irq_ctl.mtie = mie_mtie;
    assign irq_ctl.msie = mie_msie;

endmodule

/* logic/csr_timer_irq.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_timer_irq (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_wr_t   csr_wr,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::irq_ctl_t  irq_ctl,
    input  logic               irq_ext,
    input  logic               irq_soft,
    input  logic               instr_vld,
    input  logic               instr_is_intr,
    input  logic               intr_ack,
    output csr_pkg::xlen_t     rdata,
    output logic               intr_req
);

    csr_pkg::cycle_t cycle_q;
    csr_pkg::cycle_t mtimecmp_q;
    csr_pkg::xlen_t  mip_rd;
    logic            mtip;
    logic            sent_q;
    logic            pending;

    // free running, no write path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    // non-standard compare register, written as two halves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '0;
        end else if (csr_wr.en) begin
            case (csr_wr.addr)
                `CSR_ADDR_MTIMECMP:  mtimecmp_q[`CSR_XLEN-1:0] <= csr_wr.data;
                `CSR_ADDR_MTIMECMPH: mtimecmp_q[`CSR_CYCLE_W-1:`CSR_XLEN] <= csr_wr.data;
                default: ;
            endcase
        end
    end

    assign mtip = (cycle_q > mtimecmp_q);

    always_comb begin
        mip_rd = '0;
        mip_rd[`CSR_BIT_MSI] = irq_soft;
        mip_rd[`CSR_BIT_MTI] = mtip;
        mip_rd[`CSR_BIT_MEI] = irq_ext;
    end

    always_comb begin
        case (csr_addr)
            `CSR_ADDR_MIP:       rdata = mip_rd;
            `CSR_ADDR_MCYCLE,
            `CSR_ADDR_CYCLE:     rdata = cycle_q[`CSR_XLEN-1:0];
            `CSR_ADDR_MCYCLEH,
            `CSR_ADDR_CYCLEH:    rdata = cycle_q[`CSR_CYCLE_W-1:`CSR_XLEN];
            `CSR_ADDR_MTIMECMP:  rdata = mtimecmp_q[`CSR_XLEN-1:0];
            `CSR_ADDR_MTIMECMPH: rdata = mtimecmp_q[`CSR_CYCLE_W-1:`CSR_XLEN];
            default:             rdata = '0;
        endcase
    end

    // ====================
    // interrupt request
    // ====================
    // sent stays up from ack until the front end's intr instruction shows up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent_q <= 1'b0;
        end else if (intr_req && intr_ack) begin
            sent_q <= 1'b1;
        end else if (instr_vld && instr_is_intr) begin
            sent_q <= 1'b0;
        end
    end

    assign pending = (irq_ctl.meie & irq_ext) |
                     (irq_ctl.mtie & mtip) |
                     (irq_ctl.msie & irq_soft);

    assign intr_req = irq_ctl.mie & pending & ~sent_q;

endmodule

/* logic/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_vld,
    input  csr_pkg::instr_pld_t instr,
    input  logic                instr_is_intr,
    output csr_pkg::rd_wr_t     rd_wr,
    output csr_pkg::redirect_t  redirect,
    output logic                intr_req,
    input  logic                intr_ack,
    input  logic                irq_ext,
    input  logic                irq_soft
);

    csr_pkg::csr_addr_t csr_addr;
    csr_pkg::csr_wr_t   csr_wr;
    csr_pkg::trap_evt_t trap_evt;
    csr_pkg::xlen_t     trap_rdata;
    csr_pkg::xlen_t     timer_rdata;
    csr_pkg::xlen_t     mtvec;
    csr_pkg::xlen_t     mepc;
    csr_pkg::irq_ctl_t  irq_ctl;

    // decode and read merge, all combinational
    csr_exec u_exec (
        .instr_vld   (instr_vld),
        .instr       (instr),
        .trap_rdata  (trap_rdata),
        .timer_rdata (timer_rdata),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .csr_addr    (csr_addr),
        .csr_wr      (csr_wr),
        .trap_evt    (trap_evt),
        .rd_wr       (rd_wr),
        .redirect    (redirect)
    );

    csr_trap_regs u_trap_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_wr   (csr_wr),
        .csr_addr (csr_addr),
        .trap_evt (trap_evt),
        .rdata    (trap_rdata),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .irq_ctl  (irq_ctl)
    );

    csr_timer_irq u_timer_irq (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_wr        (csr_wr),
        .csr_addr      (csr_addr),
        .irq_ctl       (irq_ctl),
        .irq_ext       (irq_ext),
        .irq_soft      (irq_soft),
        .instr_vld     (instr_vld),
        .instr_is_intr (instr_is_intr),
        .intr_ack      (intr_ack),
        .rdata         (timer_rdata),
        .intr_req      (intr_req)
    );

endmodule

/* verif/csr_unit_asserts.sv */
`timescale 1ns/1ps

module csr_unit_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               instr_vld,
    input logic               intr_req,
    input logic               intr_ack,
    input csr_pkg::rd_wr_t    rd_wr,
    input csr_pkg::redirect_t redirect
);

    // redirects come only from an accepted instruction
    redirect_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.en |-> instr_vld)
        else $error("redirect.en high without instr_vld");

    // ====================
    // interrupt handshake
    // ====================
    req_drops_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (intr_req && intr_ack) |=> !intr_req)
        else $error("intr_req still high the cycle after ack");

    // write-back only with a valid instruction
    rd_wr_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
        rd_wr.en |-> instr_vld)
        else $error("rd_wr.en high without instr_vld");

endmodule

/* verif/tb_csr_unit.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module tb_csr_unit;

    localparam int CLK_PERIOD    = 4;
    localparam int RST_CYCLES    = 3;
    localparam int IRQ_CYCLES    = 80;
    localparam int MARGIN_CYCLES = 50;

    // one table row: stimulus followed by expected response
    typedef struct packed {
        csr_pkg::xlen_t word;
        csr_pkg::xlen_t rs1;
        csr_pkg::xlen_t pc;
        logic           rd_en;
        logic           is_intr;
        logic           chk_rd;
        csr_pkg::xlen_t exp_rd;
        logic           exp_redir;
        csr_pkg::xlen_t exp_target;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                instr_vld;
    csr_pkg::instr_pld_t instr;
    logic                instr_is_intr;
    csr_pkg::rd_wr_t     rd_wr;
    csr_pkg::redirect_t  redirect;
    logic                intr_req;
    logic                intr_ack;
    logic                irq_ext;
    logic                irq_soft;

    row_t           rows[$];
    csr_pkg::xlen_t got_q[$];
    logic           rows_ready;
    int             cyc_a;
    int             cyc_b;

    csr_unit uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_vld     (instr_vld),
        .instr         (instr),
        .instr_is_intr (instr_is_intr),
        .rd_wr         (rd_wr),
        .redirect      (redirect),
        .intr_req      (intr_req),
        .intr_ack      (intr_ack),
        .irq_ext       (irq_ext),
        .irq_soft      (irq_soft)
    );

    bind csr_unit csr_unit_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_vld (instr_vld),
        .intr_req  (intr_req),
        .intr_ack  (intr_ack),
        .rd_wr     (rd_wr),
        .redirect  (redirect)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // helpers
    // ====================
    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input csr_pkg::xlen_t got, input csr_pkg::xlen_t exp,
                            input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // zicsr encoding with rd = x1
    function automatic row_t csr_row(input csr_pkg::csr_addr_t addr, input logic [2:0] f3,
                                     input logic [4:0] src, input csr_pkg::xlen_t rs1,
                                     input csr_pkg::xlen_t exp_rd, input logic chk);
        row_t r;
        r            = '0;
        r.word       = {addr, src, f3, 5'd1, 7'h73};
        r.rs1        = rs1;
        r.rd_en      = 1'b1;
        r.chk_rd     = chk;
        r.exp_rd     = exp_rd;
        return r;
    endfunction

    // ecall, ebreak and mret, expecting a redirect
    function automatic row_t sys_row(input logic [11:0] f12, input csr_pkg::xlen_t pc,
                                     input csr_pkg::xlen_t target);
        row_t r;
        r            = '0;
        r.word       = {f12, 5'd0, `CSR_F3_PRIV, 5'd0, 7'h73};
        r.pc         = pc;
        r.chk_rd     = 1'b1;
        r.exp_redir  = 1'b1;
        r.exp_target = target;
        return r;
    endfunction

    task automatic apply_row(input row_t r, output csr_pkg::xlen_t got, input int idx);
        @(posedge clk);
        #1;
        instr_vld     = 1'b1;
        instr.instr   = r.word;
        instr.rs1_val = r.rs1;
        instr.pc      = r.pc;
        instr.rd_en   = r.rd_en;
        // physical index follows the row number
        instr.rd_idx  = csr_pkg::reg_idx_t'(idx);
        instr_is_intr = r.is_intr;
        @(negedge clk);
        got = rd_wr.val;
        check_eq(rd_wr.en, r.rd_en, $sformatf("row %0d rd_wr.en", idx));
        if (r.rd_en) begin
            check_eq(rd_wr.idx, csr_pkg::reg_idx_t'(idx),
                     $sformatf("row %0d rd_wr.idx", idx));
        end
        if (r.chk_rd) begin
            check_eq(rd_wr.val, r.exp_rd, $sformatf("row %0d rd_wr.val", idx));
        end
        check_eq(redirect.en, r.exp_redir, $sformatf("row %0d redirect.en", idx));
        if (r.exp_redir) begin
            check_eq(redirect.target, r.exp_target, $sformatf("row %0d target", idx));
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        instr_vld     = 1'b0;
        instr_is_intr = 1'b0;
    endtask

    task automatic wait_req(input int max_cycles, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!intr_req && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!intr_req) begin
            abort_run(what);
        end
    endtask

    // ====================
    // stimulus table
    // ====================
    task automatic build_rows();
        // read-modify-write on mscratch
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRW, 5'd1, 32'h1234_5678, 32'h0, 1));
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRS, 5'd1, 32'h0000_00f0,
                               32'h1234_5678, 1));
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRC, 5'd1, 32'h1200_0008,
                               32'h1234_56f8, 1));
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRWI, 5'd5, 0, 32'h0034_56f0, 1));
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRSI, 5'h18, 0, 32'h5, 1));
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRCI, 5'h01, 0, 32'h1d, 1));
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRS, 5'd0, 0, 32'h1c, 1));
        // field limits, bit 1 set keeps the mode at 0
        rows.push_back(csr_row(`CSR_ADDR_MTVEC, `CSR_F3_CSRRW, 5'd1, 32'h0000_1003, 32'h0, 1));
        rows.push_back(csr_row(`CSR_ADDR_MTVEC, `CSR_F3_CSRRS, 5'd0, 0, 32'h0000_1000, 1));
        rows.push_back(csr_row(`CSR_ADDR_MIE, `CSR_F3_CSRRW, 5'd1, 32'hffff_ffff, 32'h0, 1));
        rows.push_back(csr_row(`CSR_ADDR_MIE, `CSR_F3_CSRRC, 5'd1, 32'hffff_ffff, 32'h888, 1));
        rows.push_back(csr_row(`CSR_ADDR_MISA, `CSR_F3_CSRRS, 5'd0, 0, 32'h4000_0100, 1));
        rows.push_back(csr_row(`CSR_ADDR_MVENDORID, `CSR_F3_CSRRS, 5'd0, 0, 32'h0, 1));
        // counter, two reads two rows apart
        cyc_a = rows.size();
        rows.push_back(csr_row(`CSR_ADDR_MCYCLE, `CSR_F3_CSRRS, 5'd0, 0, 32'h0, 0));
        rows.push_back(csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRS, 5'd0, 0, 32'h1c, 1));
        cyc_b = rows.size();
        rows.push_back(csr_row(`CSR_ADDR_MCYCLE, `CSR_F3_CSRRS, 5'd0, 0, 32'h0, 0));
        // traps
        rows.push_back(sys_row(`CSR_F12_ECALL, 32'h0000_0100, 32'h0000_1000));
        rows.push_back(csr_row(`CSR_ADDR_MEPC, `CSR_F3_CSRRS, 5'd0, 0, 32'h0000_0100, 1));
        rows.push_back(csr_row(`CSR_ADDR_MCAUSE, `CSR_F3_CSRRS, 5'd0, 0, 32'd11, 1));
        rows.push_back(csr_row(`CSR_ADDR_MTVAL, `CSR_F3_CSRRS, 5'd0, 0, 32'h0000_0073, 1));
        rows.push_back(sys_row(`CSR_F12_EBREAK, 32'h0000_0204, 32'h0000_1000));
        rows.push_back(csr_row(`CSR_ADDR_MCAUSE, `CSR_F3_CSRRS, 5'd0, 0, 32'd3, 1));
        rows.push_back(csr_row(`CSR_ADDR_MEPC, `CSR_F3_CSRRS, 5'd0, 0, 32'h0000_0204, 1));
        // mret after setting mpie, mie comes back set
        rows.push_back(csr_row(`CSR_ADDR_MSTATUS, `CSR_F3_CSRRW, 5'd1, 32'h80, 32'h0, 1));
        rows.push_back(sys_row(`CSR_F12_MRET, 32'h0000_0300, 32'h0000_0204));
        rows.push_back(csr_row(`CSR_ADDR_MSTATUS, `CSR_F3_CSRRS, 5'd0, 0, 32'h88, 1));
    endtask

    initial begin : watchdog
        wait (rows_ready);
        #((rows.size() + RST_CYCLES + IRQ_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        abort_run("watchdog timeout, the run did not finish in time");
    end

    initial begin : main
        row_t           r;
        csr_pkg::xlen_t got;
        csr_pkg::xlen_t cyc;
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr_vld     = 1'b0;
        instr         = '0;
        instr_is_intr = 1'b0;
        intr_ack      = 1'b0;
        irq_ext       = 1'b0;
        irq_soft      = 1'b0;
        rows_ready    = 1'b0;
        build_rows();
        rows_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (rows[i]) begin
            apply_row(rows[i], got, i);
            got_q.push_back(got);
        end
        check_eq(got_q[cyc_b] - got_q[cyc_a], cyc_b - cyc_a, "mcycle delta");

        // ====================
        // software interrupt
        // ====================
        apply_row(csr_row(`CSR_ADDR_MIE, `CSR_F3_CSRRWI, 5'd8, 0, 32'h0, 1), got, 100);
        idle_cycle();
        @(negedge clk);
        check_eq(intr_req, 1'b0, "intr_req with nothing pending");
        idle_cycle();
        irq_soft = 1'b1;
        wait_req(4, "intr_req did not rise for a soft interrupt");
        idle_cycle();
        intr_ack = 1'b1;
        idle_cycle();
        intr_ack = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_eq(intr_req, 1'b0, "intr_req after ack");
        end
        r         = csr_row(`CSR_ADDR_MSCRATCH, `CSR_F3_CSRRS, 5'd0, 0, 32'h1c, 1);
        r.is_intr = 1'b1;
        apply_row(r, got, 101);
        idle_cycle();
        @(negedge clk);
        check_eq(intr_req, 1'b1, "intr_req after the intr instruction");
        idle_cycle();
        irq_soft = 1'b0;
        @(negedge clk);
        check_eq(intr_req, 1'b0, "intr_req after irq_soft dropped");

        // timer, park mtimecmp high before enabling mtie
        apply_row(csr_row(`CSR_ADDR_MTIMECMPH, `CSR_F3_CSRRW, 5'd1, 32'h1, 32'h0, 1), got, 102);
        apply_row(csr_row(`CSR_ADDR_MIE, `CSR_F3_CSRRW, 5'd1, 32'h80, 32'h8, 1), got, 103);
        apply_row(csr_row(`CSR_ADDR_MCYCLE, `CSR_F3_CSRRS, 5'd0, 0, 32'h0, 0), cyc, 104);
        apply_row(csr_row(`CSR_ADDR_MTIMECMP, `CSR_F3_CSRRW, 5'd1, cyc + 20, 32'h0, 1), got, 105);
        apply_row(csr_row(`CSR_ADDR_MTIMECMPH, `CSR_F3_CSRRW, 5'd1, 32'h0, 32'h1, 1), got, 106);
        idle_cycle();
        @(negedge clk);
        check_eq(intr_req, 1'b0, "timer interrupt before mtimecmp");
        wait_req(40, "timer interrupt was never raised");
        idle_cycle();

        $display("All tests passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/csr_pkg.sv
logic/csr_exec.sv
logic/csr_trap_regs.sv
logic/csr_timer_irq.sv
logic/csr_unit.sv
verif/csr_unit_asserts.sv
verif/tb_csr_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit \
    -f flist.f --Mdir "$BUILD_DIR" -o sim_csr_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_csr_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED, see $LOG"
    exit 1
fi
